// File: project.f
rtl/rst_mgr_pkg.sv
rtl/status_sync.sv
rtl/por_sequencer.sv
rtl/adc_init_ctrl.sv
rtl/fifo_rst_gen.sv
rtl/rst_mgr_top.sv
bench/rst_mgr_sva.sv
bench/tb_rst_mgr.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rst_mgr
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Simulation completed successfully

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_rst_mgr.sv
`timescale 1ns/100ps

module tb_rst_mgr;
	import rst_mgr_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RUN_TMO = 400;   // Worst case from reset release to RUN
	localparam int WATCHDOG_CYCLES = 8 * RUN_TMO + 2 * (POR_TMO_CYCLES + ADC_INIT_TMO_CYCLES);
	localparam int unsigned SEED = 32'h4d67_9e82;

	logic          CLK100KHZ;
	logic          EOS;
	board_status_t status_i;
	logic          jtag_sys_rst_i;
	logic          csp_sys_rst_i;
	logic          rst_resync_i;
	rst_ctrl_t     rst_o;
	logic          adc_rdy_o;
	por_state_t    por_state_o;

	int value_errs;
	int other_errs;
	int sva_errs;
	bit hold_lock_low;
	bit hold_adc_low;

	rst_mgr_top i_rst_mgr_top (.*);

	initial begin
		CLK100KHZ = 1'b0;
		forever #(CLK_PERIOD / 2) CLK100KHZ = ~CLK100KHZ;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the sequence stalled", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// Board model answering each step after a random delay
	initial begin
		int lock_wait;
		int adc_wait;
		int al_wait;
		int idle_wait;
		bit al_armed;
		status_i = '0;
		al_armed = 1'b0;
		forever begin
			@(negedge CLK100KHZ);
			if (rst_o.mmcm_rst) begin
				status_i.mmcm_lock = 1'b0;
				status_i.qpll_lock = 1'b0;
				lock_wait = 2 + $urandom % 10;
			end else if (lock_wait > 0) begin
				lock_wait--;
			end else begin
				status_i.qpll_lock = 1'b1;
				status_i.mmcm_lock = !hold_lock_low;
			end
			if (rst_o.adc_rst) begin
				status_i.adc_init_done = 1'b0;
				adc_wait = 3 + $urandom % 20;
			end else if (rst_o.adc_init && adc_wait > 0) begin
				adc_wait--;
			end else if (rst_o.adc_init) begin
				status_i.adc_init_done = !hold_adc_low;
			end
			if (rst_o.sys_rst) begin
				status_i.al_done = 1'b0;
				status_i.bpi_seq_idle = 1'b0;
				al_armed = 1'b0;
				idle_wait = 1 + $urandom % 10;
			end else if (rst_o.al_start) begin
				al_armed = 1'b1;
				al_wait = 1 + $urandom % 10;
			end else if (al_armed && al_wait > 0) begin
				al_wait--;
			end else if (al_armed) begin
				status_i.al_done = 1'b1;
			end
			if (status_i.al_done && idle_wait > 0) idle_wait--;
			else if (status_i.al_done) status_i.bpi_seq_idle = 1'b1;
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("FAIL %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_state(input por_state_t got, input por_state_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("FAIL %0t: por_state_o = %s, expected %s", $time, got.name(), exp.name());
		end
	endtask

	task automatic check_ctrl(input rst_ctrl_t got, input rst_ctrl_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("FAIL %0t: rst_o = %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			value_errs++;
			$display("FAIL %0t: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic note_error(input string msg);
		other_errs++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	task automatic wait_state(input por_state_t s, input int max);
		int n;
		n = 0;
		while (por_state_o != s && n < max) begin
			@(negedge CLK100KHZ);
			n++;
		end
		if (por_state_o != s) note_error({"state ", s.name(), " was never reached"});
	endtask

	task automatic pulse_restart(input bit from_jtag);
		jtag_sys_rst_i = from_jtag;
		csp_sys_rst_i = !from_jtag;
		@(negedge CLK100KHZ);
		jtag_sys_rst_i = 1'b0;
		csp_sys_rst_i = 1'b0;
		check_bit("rst_o.sys_rst", rst_o.sys_rst, 1'b1);
		check_bit("rst_o.run", rst_o.run, 1'b0);
		check_state(por_state_o, ST_START_DLY);
	endtask

	task automatic test_reset_values();
		rst_ctrl_t exp;
		exp = '0;
		exp.mmcm_rst = 1'b1;
		exp.sys_rst = 1'b1;
		exp.adc_rst = 1'b1;
		EOS = 1'b0;
		repeat (2) @(negedge CLK100KHZ);
		check_ctrl(rst_o, exp);
		check_state(por_state_o, ST_START_DLY);
		check_bit("adc_rdy_o", adc_rdy_o, 1'b0);
		@(negedge CLK100KHZ);
		EOS = 1'b1;
		@(negedge CLK100KHZ);
		check_bit("rst_o.sys_rst", rst_o.sys_rst, 1'b1);
		check_bit("rst_o.mmcm_rst", rst_o.mmcm_rst, 1'b1);
		check_bit("rst_o.run", rst_o.run, 1'b0);
		check_state(por_state_o, ST_START_DLY);
	endtask

	task automatic test_full_sequence();
		int n;
		int al_pulses;
		bit fifo_seen;
		bit fifo_fell;
		n = 0;
		al_pulses = 0;
		fifo_seen = 1'b0;
		fifo_fell = 1'b0;
		while (!rst_o.run && n < RUN_TMO) begin
			@(negedge CLK100KHZ);
			n++;
			if (rst_o.al_start) al_pulses++;
			if (adc_rdy_o && rst_o.sys_rst) note_error("adc_rdy high while sys_rst high");
			if (rst_o.slow_fifo_rst) fifo_seen = 1'b1;
			else if (fifo_seen) fifo_fell = 1'b1;
		end
		if (!rst_o.run) note_error("run did not rise in the full sequence");
		if (!fifo_fell) note_error("slow_fifo_rst was not seen high and then low");
		check_count("al_start pulses", al_pulses, 1);
		check_bit("adc_rdy_o", adc_rdy_o, 1'b1);
		check_state(por_state_o, ST_RUN);
	endtask

	task automatic test_lock_timeout();
		int n;
		hold_lock_low = 1'b1;
		wait_state(ST_WAIT_LOCK, 20);
		n = 0;
		while (!rst_o.mmcm_rst && n <= POR_TMO_CYCLES + 2) begin
			n++;
			@(negedge CLK100KHZ);
		end
		check_count("cycles in ST_WAIT_LOCK", n, POR_TMO_CYCLES);
		check_bit("rst_o.mmcm_rst", rst_o.mmcm_rst, 1'b1);
		check_state(por_state_o, ST_MMCM_RST);
		hold_lock_low = 1'b0;
		wait_state(ST_RUN, RUN_TMO);
	endtask

	task automatic test_adc_timeout();
		int n;
		hold_adc_low = 1'b1;
		pulse_restart(1'b1);
		n = 0;
		while (!rst_o.adc_init && n < RUN_TMO) begin
			@(negedge CLK100KHZ);
			n++;
		end
		n = 0;
		while (rst_o.adc_init && n <= ADC_INIT_TMO_CYCLES + 2) begin
			n++;
			check_bit("adc_rdy_o", adc_rdy_o, 1'b0);
			@(negedge CLK100KHZ);
		end
		check_count("cycles with adc_init high", n, ADC_INIT_TMO_CYCLES);
		check_bit("rst_o.adc_rst", rst_o.adc_rst, 1'b1);
		check_bit("adc_rdy_o", adc_rdy_o, 1'b0);
		hold_adc_low = 1'b0;
		wait_state(ST_RUN, RUN_TMO);
	endtask

	task automatic test_restart();
		pulse_restart(1'b1);
		wait_state(ST_RUN, RUN_TMO);
		check_bit("rst_o.run", rst_o.run, 1'b1);
		pulse_restart(1'b0);
		wait_state(ST_RUN, RUN_TMO);
		check_bit("rst_o.run", rst_o.run, 1'b1);
	endtask

	task automatic test_daq_fifo_reset();
		int len;
		int high;
		len = 1 + $urandom % 6;
		high = 0;
		rst_resync_i = 1'b1;
		for (int i = 0; i < len + FIFO_RST_CYCLES + 4; i++) begin
			@(negedge CLK100KHZ);
			if (i == len - 1) rst_resync_i = 1'b0;
			if (rst_o.daq_fifo_rst) high++;
			check_bit("rst_o.run", rst_o.run, 1'b1);
		end
		check_count("daq_fifo_rst high cycles", high, len + FIFO_RST_CYCLES);
	endtask

	initial begin
		void'($urandom(SEED));
		EOS = 1'b0;
		jtag_sys_rst_i = 1'b0;
		csp_sys_rst_i = 1'b0;
		rst_resync_i = 1'b0;
		hold_lock_low = 1'b0;
		hold_adc_low = 1'b0;
		value_errs = 0;
		other_errs = 0;
		test_reset_values();
		test_full_sequence();
		test_lock_timeout();
		test_adc_timeout();
		test_restart();
		test_daq_fifo_reset();
		sva_errs = i_rst_mgr_top.i_por_sequencer.i_rst_mgr_sva.fail_cnt;
		$display("Errors: %0d value, %0d other, %0d assertion", value_errs, other_errs, sva_errs);
		if (value_errs + other_errs + sva_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: bench/rst_mgr_sva.sv
`timescale 1ns/100ps

module rst_mgr_sva (
	input logic                    CLK100KHZ,
	input logic                    EOS,
	input logic                    jtag_sys_rst_i,
	input logic                    csp_sys_rst_i,
	input logic                    al_start_i,
	input logic                    run_i,
	input logic                    sys_rst_i,
	input rst_mgr_pkg::por_state_t state_i
);
	import rst_mgr_pkg::*;

	int fail_cnt = 0;   // Assertion failures so far

	a_al_start_once: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		al_start_i |=> !al_start_i)
	else begin
		fail_cnt++;
		$error("al_start high for two consecutive cycles");
	end

	a_run_no_sys_rst: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		run_i |-> !sys_rst_i)
	else begin
		fail_cnt++;
		$error("run high while sys_rst high");
	end

	// Either restart source goes back to the start-up delay
	a_restart: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		(jtag_sys_rst_i || csp_sys_rst_i) |=> (state_i == ST_START_DLY))
	else begin
		fail_cnt++;
		$error("restart request not followed by ST_START_DLY");
	end

endmodule

bind por_sequencer rst_mgr_sva i_rst_mgr_sva (
	.CLK100KHZ      (CLK100KHZ),
	.EOS            (EOS),
	.jtag_sys_rst_i (jtag_sys_rst_i),
	.csp_sys_rst_i  (csp_sys_rst_i),
	.al_start_i     (al_start_o),
	.run_i          (run_o),
	.sys_rst_i      (sys_rst_o),
	.state_i        (state_o)
);

// File: rtl/rst_mgr_top.sv
`timescale 1ns/100ps

module rst_mgr_top (
	input  logic                       CLK100KHZ,
	input  logic                       EOS,
	input  rst_mgr_pkg::board_status_t status_i,
	input  logic                       jtag_sys_rst_i,
	input  logic                       csp_sys_rst_i,
	input  logic                       rst_resync_i,
	output rst_mgr_pkg::rst_ctrl_t     rst_o,
	output logic                       adc_rdy_o,
	output rst_mgr_pkg::por_state_t    por_state_o
);
	import rst_mgr_pkg::*;

	board_status_t sync_status;
	logic          mmcm_rst;
	logic          sys_rst;
	logic          adc_init_rst;
	logic          al_start;
	logic          run;
	logic          adc_rst;
	logic          adc_init;
	logic          slow_fifo_rst;
	logic          slow_fifo_done;
	logic          daq_fifo_rst;

	status_sync i_status_sync (
		.CLK100KHZ (CLK100KHZ),
		.EOS       (EOS),
		.status_i  (status_i),
		.status_o  (sync_status)
	);

	por_sequencer i_por_sequencer (
		.CLK100KHZ        (CLK100KHZ),
		.EOS              (EOS),
		.status_i         (sync_status),
		.jtag_sys_rst_i   (jtag_sys_rst_i),
		.csp_sys_rst_i    (csp_sys_rst_i),
		.slow_fifo_done_i (slow_fifo_done),
		.adc_rdy_i        (adc_rdy_o),
		.mmcm_rst_o       (mmcm_rst),
		.sys_rst_o        (sys_rst),
		.adc_init_rst_o   (adc_init_rst),
		.al_start_o       (al_start),
		.run_o            (run),
		.state_o          (por_state_o)
	);

	adc_init_ctrl i_adc_init_ctrl (
		.CLK100KHZ      (CLK100KHZ),
		.EOS            (EOS),
		.adc_init_rst_i (adc_init_rst),
		.init_done_i    (sync_status.adc_init_done),
		.adc_rst_o      (adc_rst),
		.adc_init_o     (adc_init),
		.adc_rdy_o      (adc_rdy_o)
	);

	// Auto-load FIFO cleared on sys_rst release
	fifo_rst_gen i_slow_fifo_rst (
		.CLK100KHZ  (CLK100KHZ),
		.EOS        (EOS),
		.trig_i     (sys_rst),
		.fifo_rst_o (slow_fifo_rst),
		.done_o     (slow_fifo_done)
	);

	fifo_rst_gen i_daq_fifo_rst (
		.CLK100KHZ  (CLK100KHZ),
		.EOS        (EOS),
		.trig_i     (rst_resync_i),
		.fifo_rst_o (daq_fifo_rst),
		.done_o     ()
	);

	assign rst_o = '{
		mmcm_rst:      mmcm_rst,
		sys_rst:       sys_rst,
		adc_rst:       adc_rst,
		adc_init:      adc_init,
		al_start:      al_start,
		run:           run,
		slow_fifo_rst: slow_fifo_rst,
		daq_fifo_rst:  daq_fifo_rst
	};

endmodule

// File: rtl/fifo_rst_gen.sv
`timescale 1ns/100ps

module fifo_rst_gen (
	input  logic CLK100KHZ,
	input  logic EOS,
	input  logic trig_i,
	output logic fifo_rst_o,
	output logic done_o
);
	import rst_mgr_pkg::*;

	fifo_cnt_t cnt_q;   // Cycles of stretch left

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			cnt_q      <= '0;
			fifo_rst_o <= 1'b0;
			done_o     <= 1'b0;
		end else if (trig_i) begin
			cnt_q      <= fifo_cnt_t'(FIFO_RST_CYCLES);   // Restarts a running stretch
			fifo_rst_o <= 1'b1;
			done_o     <= 1'b0;
		end else if (cnt_q != '0) begin
			cnt_q      <= cnt_q - 1'b1;
			fifo_rst_o <= 1'b1;
			done_o     <= 1'b0;
		end else begin
			fifo_rst_o <= 1'b0;
			done_o     <= fifo_rst_o;   // High only in the falling cycle
		end
	end

endmodule

// File: rtl/adc_init_ctrl.sv
`timescale 1ns/100ps

module adc_init_ctrl (
	input  logic CLK100KHZ,
	input  logic EOS,
	input  logic adc_init_rst_i,
	input  logic init_done_i,   // Already synchronized
	output logic adc_rst_o,
	output logic adc_init_o,
	output logic adc_rdy_o
);
	import rst_mgr_pkg::*;

	typedef enum logic [1:0] {
		ADC_RST,
		ADC_INIT,
		ADC_READY
	} adc_state_t;

	adc_state_t state_q;
	adc_tmr_t   tmr_q;     // Reset width and then init timeout

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			state_q <= ADC_RST;
			tmr_q   <= '0;
		end else if (adc_init_rst_i) begin
			state_q <= ADC_RST;
			tmr_q   <= '0;
		end else begin
			case (state_q)
				ADC_RST: begin
					if (tmr_q == adc_tmr_t'(ADC_RST_CYCLES - 1)) begin
						state_q <= ADC_INIT;
						tmr_q   <= '0;
					end else begin
						tmr_q <= tmr_q + 1'b1;
					end
				end
				ADC_INIT: begin
					if (init_done_i) begin
						state_q <= ADC_READY;
						tmr_q   <= '0;
					end else if (tmr_q == adc_tmr_t'(ADC_INIT_TMO_CYCLES - 1)) begin
						state_q <= ADC_RST;   // Timed out so the ADC is reset again
						tmr_q   <= '0;
					end else begin
						tmr_q <= tmr_q + 1'b1;
					end
				end
				ADC_READY: begin
					tmr_q <= '0;
				end
				default: begin
					state_q <= ADC_RST;
					tmr_q   <= '0;
				end
			endcase
		end
	end

	// Init reset request takes effect in the same cycle
	assign adc_rst_o  = adc_init_rst_i || (state_q == ADC_RST);
	assign adc_init_o = !adc_init_rst_i && (state_q == ADC_INIT);
	assign adc_rdy_o  = !adc_init_rst_i && (state_q == ADC_READY);

endmodule

// File: rtl/por_sequencer.sv
`timescale 1ns/100ps

module por_sequencer (
	input  logic                       CLK100KHZ,
	input  logic                       EOS,
	input  rst_mgr_pkg::board_status_t status_i,
	input  logic                       jtag_sys_rst_i,
	input  logic                       csp_sys_rst_i,
	input  logic                       slow_fifo_done_i,
	input  logic                       adc_rdy_i,
	output logic                       mmcm_rst_o,
	output logic                       sys_rst_o,
	output logic                       adc_init_rst_o,
	output logic                       al_start_o,
	output logic                       run_o,
	output rst_mgr_pkg::por_state_t    state_o
);
	import rst_mgr_pkg::*;

	por_state_t state_q;
	por_state_t state_d;
	dly_cnt_t   cnt_q;     // Shared by delay, reset width and timeout
	dly_cnt_t   cnt_d;
	logic       restart;
	logic       locked;

	assign restart = jtag_sys_rst_i | csp_sys_rst_i;
	assign locked  = status_i.mmcm_lock & status_i.qpll_lock;

	always_comb begin
		state_d = state_q;
		cnt_d   = '0;
		case (state_q)
			ST_START_DLY: begin
				if (cnt_q == dly_cnt_t'(STRT_DLY_CYCLES - 1)) begin
					state_d = ST_MMCM_RST;
				end else begin
					cnt_d = cnt_q + 1'b1;
				end
			end
			ST_MMCM_RST: begin
				if (cnt_q == dly_cnt_t'(MMCM_RST_CYCLES - 1)) begin
					state_d = ST_WAIT_LOCK;
				end else begin
					cnt_d = cnt_q + 1'b1;
				end
			end
			ST_WAIT_LOCK: begin
				if (locked) begin
					state_d = ST_SLOW_FIFO;
				end else if (cnt_q == dly_cnt_t'(POR_TMO_CYCLES - 1)) begin
					state_d = ST_MMCM_RST;   // Pulse the clock manager reset again
				end else begin
					cnt_d = cnt_q + 1'b1;
				end
			end
			ST_SLOW_FIFO: begin
				if (slow_fifo_done_i) begin
					state_d = ST_ADC_INIT;
				end
			end
			ST_ADC_INIT: begin
				if (adc_rdy_i) begin
					state_d = ST_AUTO_LOAD;
				end
			end
			ST_AUTO_LOAD: begin
				if (status_i.al_done) begin
					state_d = ST_WAIT_IDLE;
				end
			end
			ST_WAIT_IDLE: begin
				if (status_i.bpi_seq_idle) begin
					state_d = ST_RUN;
				end
			end
			ST_RUN: begin
				if (!locked) begin
					state_d = ST_MMCM_RST;   // Lost a lock
				end
			end
			default: begin
				state_d = ST_START_DLY;
			end
		endcase

		// A restart request wins over every state
		if (restart) begin
			state_d = ST_START_DLY;
			cnt_d   = '0;
		end
	end

	// Outputs follow the next state so they change with the state register
	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			state_q        <= ST_START_DLY;
			cnt_q          <= '0;
			mmcm_rst_o     <= 1'b1;
			sys_rst_o      <= 1'b1;
			adc_init_rst_o <= 1'b1;
			al_start_o     <= 1'b0;
			run_o          <= 1'b0;
		end else begin
			state_q        <= state_d;
			cnt_q          <= cnt_d;
			mmcm_rst_o     <= state_d inside {ST_START_DLY, ST_MMCM_RST};
			sys_rst_o      <= state_d inside {ST_START_DLY, ST_MMCM_RST, ST_WAIT_LOCK};
			adc_init_rst_o <= state_d inside {ST_START_DLY, ST_MMCM_RST, ST_WAIT_LOCK,
				ST_SLOW_FIFO};
			al_start_o     <= (state_d == ST_AUTO_LOAD) && (state_q != ST_AUTO_LOAD);
			run_o          <= (state_d == ST_RUN);
		end
	end

	assign state_o = state_q;

endmodule

// File: rtl/status_sync.sv
`timescale 1ns/100ps

module status_sync (
	input  logic                       CLK100KHZ,
	input  logic                       EOS,
	input  rst_mgr_pkg::board_status_t status_i,
	output rst_mgr_pkg::board_status_t status_o
);
	import rst_mgr_pkg::*;

	board_status_t meta_q;   // First stage that may go metastable
	board_status_t sync_q;

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			meta_q <= '0;
			sync_q <= '0;
		end else begin
			meta_q <= status_i;
			sync_q <= meta_q;
		end
	end

	assign status_o = sync_q;

endmodule

// File: rtl/rst_mgr_pkg.sv
package rst_mgr_pkg;

	// Start-up sequence lengths in CLK100KHZ cycles
	localparam int STRT_DLY_CYCLES     = 64;
	localparam int MMCM_RST_CYCLES     = 4;
	localparam int POR_TMO_CYCLES      = 120;   // Lock wait before retry
	localparam int ADC_RST_CYCLES      = 4;
	localparam int ADC_INIT_TMO_CYCLES = 1000;  // 10 ms at 100 kHz
	localparam int FIFO_RST_CYCLES     = 8;     // Stretch after trigger falls

	typedef logic [7:0]  dly_cnt_t;   // Start-up delay and lock timeout
	typedef logic [11:0] adc_tmr_t;
	typedef logic [3:0]  fifo_cnt_t;

	typedef enum logic [3:0] {
		ST_START_DLY,
		ST_MMCM_RST,
		ST_WAIT_LOCK,
		ST_SLOW_FIFO,   // sys_rst released here
		ST_ADC_INIT,
		ST_AUTO_LOAD,
		ST_WAIT_IDLE,
		ST_RUN
	} por_state_t;

	// Asynchronous levels from the board
	typedef struct packed {
		logic mmcm_lock;
		logic qpll_lock;
		logic adc_init_done;
		logic al_done;
		logic bpi_seq_idle;   // Flash sequencer idle
	} board_status_t;

	typedef struct packed {
		logic mmcm_rst;
		logic sys_rst;
		logic adc_rst;
		logic adc_init;
		logic al_start;       // One-cycle auto-load start
		logic run;
		logic slow_fifo_rst;
		logic daq_fifo_rst;
	} rst_ctrl_t;

endpackage
